/* verilog/cr16_pkg.sv */
// shared types, opcode values and flag positions for the cr16 multicycle core; used by scoped name
package cr16_pkg;

    // widths that carry a meaning
    typedef logic [15:0] word_t;    // register value, alu operand, instruction
    typedef logic [3:0]  reg_idx_t; // register file index
    typedef logic [3:0]  opcode_t;  // alu operation code
    typedef logic [4:0]  flags_t;   // condition flags

    // control fsm, one instruction per pass
    typedef enum logic [1:0] {
        s_fetch   = 2'd0, // pc out, ir loads
        s_decode  = 2'd1, // fields valid
        s_execute = 2'd2  // alu, writeback, flags, pc+1
    } state_t;

    // opcodes, rr form in ir[7:4], ri form in ir[15:12]
    localparam opcode_t op_nop  = 4'b0000;
    localparam opcode_t op_and  = 4'b0001; // logical imm is zero extended
    localparam opcode_t op_or   = 4'b0010;
    localparam opcode_t op_xor  = 4'b0011;
    localparam opcode_t op_lsh  = 4'b0100; // signed count in b[4:0]
    localparam opcode_t op_add  = 4'b0101; // sets c and f
    localparam opcode_t op_addu = 4'b0110; // flags untouched
    localparam opcode_t op_addc = 4'b0111; // adds carry in
    localparam opcode_t op_not  = 4'b1000; // inverts b
    localparam opcode_t op_sub  = 4'b1001; // c is the borrow
    localparam opcode_t op_subc = 4'b1010; // subtracts carry in
    localparam opcode_t op_cmp  = 4'b1011; // z n l only, no writeback
    localparam opcode_t op_ashu = 4'b1100; // arithmetic right shift
    localparam opcode_t op_mov  = 4'b1101; // rdest <= b

    // bit positions inside flags_t
    localparam int flag_c = 0; // carry / borrow
    localparam int flag_l = 1; // unsigned less
    localparam int flag_f = 2; // signed overflow
    localparam int flag_n = 3; // signed less
    localparam int flag_z = 4; // equal

endpackage

/* verilog/cr16_fetch.sv */
// fetch stage of the cr16 core; holds the program counter and instruction register under control enables
`timescale 1ns/10ps

module cr16_fetch #(
    parameter int pc_width = 8 // reach of the instruction memory
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pc_en, // high in execute
    input  logic                 ir_en, // high in fetch
    input  cr16_pkg::word_t      instr, // from the combinational imem
    output logic [pc_width-1:0]  pc,
    output cr16_pkg::word_t      ir
);

    // program counter, wraps at its width
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (pc_en) begin
            pc <= pc + 1'b1; // next instruction
        end
    end

    // instruction register, holds through decode and execute
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= '0; // decodes as rr nop
        end else if (ir_en) begin
            ir <= instr; // capture at end of fetch
        end
    end

endmodule

/* verilog/cr16_control.sv */
// decode and control stage of the cr16 core; runs the fetch/decode/execute fsm and splits ir into fields
`timescale 1ns/10ps

module cr16_control (
    input  logic                clk,
    input  logic                reset,
    input  cr16_pkg::word_t     ir,       // registered instruction
    output logic                pc_en,    // pc+1 at end of execute
    output logic                ir_en,    // ir <= instr at end of fetch
    output logic                reg_we,   // regfile write strobe
    output logic [15:0]         reg_en,   // one-hot write select
    output logic                imm_en,   // 1 selects imm8 as operand b
    output logic                flag_en,  // flag register update
    output cr16_pkg::opcode_t   op,
    output cr16_pkg::reg_idx_t  rdest,
    output cr16_pkg::reg_idx_t  rsrc,
    output logic [7:0]          imm8,
    output logic                wb_valid  // trace strobe
);

    cr16_pkg::state_t state;      // current state
    cr16_pkg::state_t state_next;
    logic             op_writes;  // opcode has a result to store
    logic             op_flags;   // opcode touches the flags
    logic             in_exec;

    // fsm, one instruction every three cycles
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= cr16_pkg::s_fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            cr16_pkg::s_fetch:   state_next = cr16_pkg::s_decode;
            cr16_pkg::s_decode:  state_next = cr16_pkg::s_execute;
            cr16_pkg::s_execute: state_next = cr16_pkg::s_fetch; // back for the next word
            default:             state_next = cr16_pkg::s_fetch; // unused code
        endcase
    end

    // field decoder, top nibble zero means register-register
    always_comb begin
        imm_en = (ir[15:12] != 4'b0000);
        op     = imm_en ? ir[15:12] : ir[7:4];
        rdest  = ir[11:8]; // same place in both forms
        rsrc   = ir[3:0];  // only meaningful for rr
        imm8   = ir[7:0];  // only meaningful for ri
    end

    // opcode classes
    always_comb begin
        op_writes = (op != cr16_pkg::op_cmp) && (op != cr16_pkg::op_nop);
        op_flags  = (op == cr16_pkg::op_add)  || (op == cr16_pkg::op_addc) ||
                    (op == cr16_pkg::op_sub)  || (op == cr16_pkg::op_subc) ||
                    (op == cr16_pkg::op_cmp);
    end

    // enables, decode raises none of them
    always_comb begin
        in_exec  = (state == cr16_pkg::s_execute);
        ir_en    = (state == cr16_pkg::s_fetch);
        pc_en    = in_exec;
        reg_we   = in_exec && op_writes;
        flag_en  = in_exec && op_flags;
        wb_valid = reg_we; // trace follows the write
        reg_en   = reg_we ? (16'd1 << rdest) : 16'd0;
    end

endmodule

/* verilog/cr16_regfile.sv */
// register file of the cr16 core; sixteen words, two combinational reads and a one-hot write
`timescale 1ns/10ps

module cr16_regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic                reg_we,  // write strobe from control
    input  logic [15:0]         reg_en,  // one-hot target
    input  cr16_pkg::word_t     wdata,   // alu result
    input  cr16_pkg::reg_idx_t  rdest,   // read port a, also the target
    input  cr16_pkg::reg_idx_t  rsrc,    // read port b
    output cr16_pkg::word_t     rd_data, // operand a
    output cr16_pkg::word_t     rs_data  // operand b in rr form
);

    cr16_pkg::word_t regs [16]; // r0..r15, r0 is an ordinary register

    // writes land at the end of execute
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            for (int i = 0; i < 16; i++) begin
                if (reg_en[i]) begin
                    regs[i] <= wdata; // only the selected slot
                end
            end
        end
    end

    // reads are combinational, valid from decode on
    assign rd_data = regs[rdest];
    assign rs_data = regs[rsrc];

endmodule

/* verilog/cr16_execute.sv */
// execute stage of the cr16 core; operand b select and extension, alu and the flag register
`timescale 1ns/10ps

module cr16_execute (
    input  logic               clk,
    input  logic               reset,
    input  cr16_pkg::opcode_t  op,
    input  logic               imm_en,  // operand b from imm8
    input  logic [7:0]         imm8,
    input  logic               flag_en, // high in execute for flag ops
    input  cr16_pkg::word_t    rd_data, // operand a
    input  cr16_pkg::word_t    rs_data,
    output cr16_pkg::word_t    result,
    output cr16_pkg::flags_t   flags
);

    cr16_pkg::word_t  a;
    cr16_pkg::word_t  b;
    cr16_pkg::word_t  imm_ext;
    logic             cin;        // carry into addc and subc
    logic [16:0]      sum;        // bit 16 is carry out
    logic [16:0]      diff;       // bit 16 is the borrow
    logic [4:0]       sh_cnt;     // signed shift count
    logic [4:0]       sh_amt;     // magnitude of a right shift
    logic signed [15:0] a_s;
    cr16_pkg::word_t  sh_left;
    cr16_pkg::word_t  sh_rlog;
    cr16_pkg::word_t  sh_rari;
    cr16_pkg::flags_t flags_next;

    // operand select, logical ops take a zero extended imm
    always_comb begin
        if ((op == cr16_pkg::op_and) || (op == cr16_pkg::op_or) || (op == cr16_pkg::op_xor)) begin
            imm_ext = {8'h00, imm8};
        end else begin
            imm_ext = {{8{imm8[7]}}, imm8}; // sign extend
        end
        a = rd_data;
        b = imm_en ? imm_ext : rs_data;
    end

    // adder, subtractor and shifter run every cycle
    always_comb begin
        cin     = ((op == cr16_pkg::op_addc) || (op == cr16_pkg::op_subc)) ?
                  flags[cr16_pkg::flag_c] : 1'b0;
        sum     = {1'b0, a} + {1'b0, b} + {16'd0, cin};
        diff    = {1'b0, a} - {1'b0, b} - {16'd0, cin};
        sh_cnt  = b[4:0];
        sh_amt  = 5'd0 - sh_cnt; // negate for right shifts
        a_s     = a;
        sh_left = a << sh_cnt[3:0];
        sh_rlog = a >> sh_amt;
        sh_rari = a_s >>> sh_amt; // sign fill
    end

    // result mux
    always_comb begin
        case (op)
            cr16_pkg::op_add,
            cr16_pkg::op_addu,
            cr16_pkg::op_addc: result = sum[15:0];
            cr16_pkg::op_sub,
            cr16_pkg::op_subc,
            cr16_pkg::op_cmp:  result = diff[15:0]; // cmp result is dropped
            cr16_pkg::op_and:  result = a & b;
            cr16_pkg::op_or:   result = a | b;
            cr16_pkg::op_xor:  result = a ^ b;
            cr16_pkg::op_not:  result = ~b;
            cr16_pkg::op_mov:  result = b;
            cr16_pkg::op_lsh:  result = sh_cnt[4] ? sh_rlog : sh_left;
            cr16_pkg::op_ashu: result = sh_cnt[4] ? sh_rari : sh_left;
            default:           result = a; // nop
        endcase
    end

    // candidate flags, untouched bits hold
    always_comb begin
        flags_next = flags;
        case (op)
            cr16_pkg::op_add,
            cr16_pkg::op_addc: begin
                flags_next[cr16_pkg::flag_c] = sum[16];
                flags_next[cr16_pkg::flag_f] = (a[15] == b[15]) && (sum[15] != a[15]);
            end
            cr16_pkg::op_sub,
            cr16_pkg::op_subc: begin
                flags_next[cr16_pkg::flag_c] = diff[16];
                flags_next[cr16_pkg::flag_f] = (a[15] != b[15]) && (diff[15] != a[15]);
            end
            cr16_pkg::op_cmp: begin
                flags_next[cr16_pkg::flag_z] = (a == b);
                flags_next[cr16_pkg::flag_n] = ($signed(a) < $signed(b));
                flags_next[cr16_pkg::flag_l] = (a < b); // unsigned
            end
            default: flags_next = flags;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            flags <= '0;
        end else if (flag_en) begin
            flags <= flags_next; // end of execute
        end
    end

endmodule

/* verilog/cr16_core.sv */
// top level of the cr16 multicycle core; joins the stages to the instruction memory and writeback trace
`timescale 1ns/10ps

module cr16_core #(
    parameter int pc_width = 8 // instruction memory reach
) (
    input  logic                 clk,
    input  logic                 reset,
    input  cr16_pkg::word_t      instr,    // imem data for pc, same cycle
    output logic [pc_width-1:0]  pc,
    output logic                 wb_valid, // execute cycle of a writing op
    output cr16_pkg::reg_idx_t   wb_reg,
    output cr16_pkg::word_t      wb_data,
    output cr16_pkg::flags_t     flags
);

    logic               pc_en;
    logic               ir_en;
    cr16_pkg::word_t    ir;
    logic               reg_we;
    logic [15:0]        reg_en;
    logic               imm_en;
    logic               flag_en;
    cr16_pkg::opcode_t  op;
    cr16_pkg::reg_idx_t rdest;
    cr16_pkg::reg_idx_t rsrc;
    logic [7:0]         imm8;
    cr16_pkg::word_t    rd_data;
    cr16_pkg::word_t    rs_data;
    cr16_pkg::word_t    result;

    cr16_fetch #(
        .pc_width (pc_width)
    ) u_fetch (
        .clk   (clk),
        .reset (reset),
        .pc_en (pc_en),
        .ir_en (ir_en),
        .instr (instr),
        .pc    (pc),
        .ir    (ir)
    );

    cr16_control u_control (
        .clk      (clk),
        .reset    (reset),
        .ir       (ir),
        .pc_en    (pc_en),
        .ir_en    (ir_en),
        .reg_we   (reg_we),
        .reg_en   (reg_en),
        .imm_en   (imm_en),
        .flag_en  (flag_en),
        .op       (op),
        .rdest    (rdest),
        .rsrc     (rsrc),
        .imm8     (imm8),
        .wb_valid (wb_valid)
    );

    cr16_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .reg_we  (reg_we),
        .reg_en  (reg_en),
        .wdata   (result),
        .rdest   (rdest),
        .rsrc    (rsrc),
        .rd_data (rd_data),
        .rs_data (rs_data)
    );

    cr16_execute u_execute (
        .clk     (clk),
        .reset   (reset),
        .op      (op),
        .imm_en  (imm_en),
        .imm8    (imm8),
        .flag_en (flag_en),
        .rd_data (rd_data),
        .rs_data (rs_data),
        .result  (result),
        .flags   (flags)
    );

    // trace taps
    assign wb_reg  = rdest;  // write target
    assign wb_data = result; // value going into the regfile

endmodule

/* test/cr16_core_checker.sv */
// assertions on the control fsm order and its enables; bound into every cr16_control instance
`timescale 1ns/10ps

module cr16_core_checker (
    input logic             clk,
    input logic             reset,
    input cr16_pkg::state_t state,
    input logic             pc_en,
    input logic             reg_we,
    input logic [15:0]      reg_en
);

    // fetch, decode, execute, then back to fetch
    a_fetch_decode: assert property (@(posedge clk) disable iff (!reset)
        (state == cr16_pkg::s_fetch) |=> (state == cr16_pkg::s_decode))
        else $error("fsm left fetch for a state other than decode");
    a_decode_execute: assert property (@(posedge clk) disable iff (!reset)
        (state == cr16_pkg::s_decode) |=> (state == cr16_pkg::s_execute))
        else $error("fsm left decode for a state other than execute");
    a_execute_fetch: assert property (@(posedge clk) disable iff (!reset)
        (state == cr16_pkg::s_execute) |=> (state == cr16_pkg::s_fetch))
        else $error("fsm left execute for a state other than fetch");
    a_reg_en_onehot: assert property (@(posedge clk) disable iff (!reset)
        reg_we |-> $onehot(reg_en))
        else $error("reg_en not one-hot during a register write");
    a_pc_en_execute: assert property (@(posedge clk) disable iff (!reset)
        pc_en |-> (state == cr16_pkg::s_execute))
        else $error("pc_en high outside the execute state");

endmodule

bind cr16_control cr16_core_checker u_checker (
    .clk    (clk),
    .reset  (reset),
    .state  (state),
    .pc_en  (pc_en),
    .reg_we (reg_we),
    .reg_en (reg_en)
);

/* test/cr16_core_tb.sv */
// testbench for cr16_core; plays the instruction memory from the vectors file, checks trace and flags
`timescale 1ns/10ps

module cr16_core_tb;

    localparam int num_vec     = 23;              // program words in the vectors file
    localparam int cycle_limit = 3 * num_vec + 20; // three cycles per word plus margin

    logic               clk;
    logic               reset;
    cr16_pkg::word_t    instr;
    logic [7:0]         pc;
    logic               wb_valid;
    cr16_pkg::reg_idx_t wb_reg;
    cr16_pkg::word_t    wb_data;
    cr16_pkg::flags_t   flags;

    logic [15:0] vec_mem [0:num_vec*5-1]; // word, wb, reg, data, flags per line
    int          value_errors;
    int          other_errors;
    int          cycle_count;
    int          instr_cycles; // cycles spent on the current pc
    logic [7:0]  last_pc;
    logic        seen_wb;      // trace seen for the current pc
    logic        wb_prev;
    logic        done;

    cr16_core #(
        .pc_width (8)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .pc       (pc),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .flags    (flags)
    );

    always #4 clk = ~clk; // 8 ns period

    // combinational imem, nop past the program
    assign instr = (pc < num_vec) ? vec_mem[pc*5] : 16'h0000;

    task automatic check(input string name, input logic [15:0] expected, input logic [15:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("[FAIL] %0d ns %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("error at %0d ns: %s", $time, what);
    endtask

    // outputs sampled on the falling edge, mid cycle
    always @(negedge clk) begin
        if (reset && !done) begin
            if (pc != last_pc) begin // word at last_pc has retired
                check("pc", last_pc + 8'd1, pc);
                check("instr_cycles", 16'd3, instr_cycles[15:0]);
                if (vec_mem[last_pc*5+1][0] && !seen_wb) begin
                    report_problem($sformatf("no wb_valid for the word at pc %0d", last_pc));
                end
                check("flags", vec_mem[last_pc*5+4], flags);
                last_pc      = pc;
                seen_wb      = 1'b0;
                instr_cycles = 0;
                done         = (pc == num_vec); // whole program retired
            end
            instr_cycles++;
            if (wb_valid) begin
                if (wb_prev) begin
                    report_problem("wb_valid high in two consecutive cycles");
                end
                if ((pc >= num_vec) || !vec_mem[pc*5+1][0]) begin
                    report_problem($sformatf("unexpected wb_valid for the word at pc %0d", pc));
                end else begin
                    check("wb_reg", vec_mem[pc*5+2], wb_reg);
                    check("wb_data", vec_mem[pc*5+3], wb_data);
                end
                seen_wb = 1'b1;
            end
            wb_prev = wb_valid;
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b0; // held for three rising edges
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        instr_cycles = 0;
        last_pc      = 8'd0;
        seen_wb      = 1'b0;
        wb_prev      = 1'b0;
        done         = 1'b0;
        $readmemh("test/cr16_core_vectors.txt", vec_mem);
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check("pc", 16'h0000, pc); // state right after reset
        check("flags", 16'h0000, flags);
        check("wb_valid", 16'h0000, wb_valid);
        while (!done && (cycle_count < cycle_limit)) begin
            @(posedge clk);
            cycle_count++;
        end
        if (!done) begin
            report_problem("timeout, the program did not reach its end");
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if ((value_errors + other_errors) == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/cr16_core_vectors.txt */
// columns: program word, writeback expected, register, data, flags after execute (all hex)
// flags bits: c=01 l=02 f=04 n=08 z=10; reg and data are 0 where no writeback is expected
d17f 1 1 007f 00 // mov r1, 0x7f
d280 1 2 ff80 00 // mov r2, -128 sign extended
d37f 1 3 007f 00 // mov r3, 0x7f
4308 1 3 7f00 00 // lsh r3, 8
23ff 1 3 7fff 00 // or r3, 0xff zero extended
5401 1 4 0001 00 // add r4, 1
0354 1 3 8000 04 // add r3, r4 overflow
0353 1 3 0000 05 // add r3, r3 carry and overflow
7402 1 4 0004 00 // addc r4, 2 with carry in
0594 1 5 fffc 01 // sub r5, r4 borrow
a401 1 4 0002 00 // subc r4, 1 with borrow in
0562 1 5 ff7c 00 // addu r5, r2 flags held
15f0 1 5 0070 00 // and r5, 0xf0 zero extended
0231 1 2 ffff 00 // xor r2, r1
0685 1 6 ff8f 00 // not r6, r5
42fc 1 2 0fff 00 // lsh r2, -4 logical right
d790 1 7 ff90 00 // mov r7, -112
c7fc 1 7 fff9 00 // ashu r7, -4 arithmetic right
07b7 0 0 0000 10 // cmp r7, r7 equal
04b7 0 0 0000 02 // cmp r4, r7 unsigned less
07b4 0 0 0000 08 // cmp r7, r4 signed less
0000 0 0 0000 08 // nop
08d7 1 8 fff9 08 // mov r8, r7 read back

/* cr16_core.f */
verilog/cr16_pkg.sv
verilog/cr16_fetch.sv
verilog/cr16_control.sv
verilog/cr16_regfile.sv
verilog/cr16_execute.sv
verilog/cr16_core.sv
test/cr16_core_checker.sv
test/cr16_core_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cr16_core_tb \
    -f cr16_core.f -o cr16_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/cr16_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "TESTS PASSED" sim.log && echo "simulation run ok" || { echo "simulation run failed"; exit 1; }
